//--- design/RamBlockPkg.sv
// Shared enums for the external SRAM block.
// Every module refers to these through RamBlockPkg:: scoped names.
package RamBlockPkg;

	// Direction of one SRAM access
	typedef enum logic [0:0]
	{
		cmdRead  = 1'b0,
		cmdWrite = 1'b1
	} RamCmd;

	// Host register offsets, word select in usiAdrs[2:0]
	typedef enum logic [2:0]
	{
		regCtrl   = 3'd0,	// bit 0 starts the tester
		regSeed   = 3'd1,	// tester pattern seed
		regAdrs   = 3'd2,	// host SRAM address
		regWdata  = 3'd3,	// write starts a host write
		regRdata  = 3'd4,	// write starts a host read
		regStatus = 3'd5	// busy, done, error
	} CsrReg;

	// Memory tester sequence
	typedef enum logic [2:0] {tstIdle, tstWrite, tstRead, tstDone} TesterState;

	// SRAM pin timing phases
	typedef enum logic [1:0] {portIdle, portSetup, portStrobe, portHold} PortState;

endpackage

//--- design/RamIfPortUnit.sv
// SRAM pin driver for one access at a time.
// portStart runs setup, strobe and hold, one cycle each, and portDone
// pulses in the hold cycle. Strobes are active low and registered.
// Byte lanes are always enabled together.
`timescale 1ns/1ps

module RamIfPortUnit #(
	parameter pRamAdrsWidth = 18,
	parameter pRamDqWidth = 16
)(
	input  logic sClk,
	input  logic reset,
	input  logic portStart,
	input  RamBlockPkg::RamCmd portCmd,
	input  logic [pRamAdrsWidth-1:0] portAdrs,
	input  logic [pRamDqWidth-1:0] portWd,
	output logic [pRamDqWidth-1:0] portRd,
	output logic portDone,
	input  logic [pRamDqWidth-1:0] sramDin,
	output logic [pRamAdrsWidth-1:0] sramA,
	output logic [pRamDqWidth-1:0] sramDout,
	output logic sramDoe,
	output logic sramLb,
	output logic sramUb,
	output logic sramOe,
	output logic sramWe,
	output logic sramCe
);

	RamBlockPkg::PortState state;
	RamBlockPkg::RamCmd cmdReg;
	logic laneN;

	// Both lanes share one enable
	assign sramLb = laneN;
	assign sramUb = laneN;

	always_ff @(posedge sClk)
	begin
		if (reset)
		begin
			state <= RamBlockPkg::portIdle;
			portDone <= 1'b0;
			sramCe <= 1'b1;
			sramOe <= 1'b1;
			sramWe <= 1'b1;
			sramDoe <= 1'b0;
			laneN <= 1'b1;
		end
		else
		begin
			portDone <= 1'b0;
			case (state)
				RamBlockPkg::portIdle:
				begin
					if (portStart)
					begin
						state <= RamBlockPkg::portSetup;
						laneN <= 1'b0;
						// Write data drives from setup through hold
						sramDoe <= (portCmd == RamBlockPkg::cmdWrite);
					end
				end
				RamBlockPkg::portSetup:
				begin
					state <= RamBlockPkg::portStrobe;
					sramCe <= 1'b0;
					sramOe <= (cmdReg != RamBlockPkg::cmdRead);
					sramWe <= (cmdReg != RamBlockPkg::cmdWrite);
				end
				RamBlockPkg::portStrobe:
				begin
					state <= RamBlockPkg::portHold;
					sramCe <= 1'b1;
					sramOe <= 1'b1;
					sramWe <= 1'b1;
					portDone <= 1'b1;
				end
				default:
				begin
					// Hold cycle, release the bus
					state <= RamBlockPkg::portIdle;
					laneN <= 1'b1;
					sramDoe <= 1'b0;
				end
			endcase
		end
	end

	// Address and data held for the whole access; read sampled at strobe end
	always_ff @(posedge sClk)
	begin
		if ((state == RamBlockPkg::portIdle) && portStart)
		begin
			cmdReg <= portCmd;
			sramA <= portAdrs;
			sramDout <= portWd;
		end
		if ((state == RamBlockPkg::portStrobe) && (cmdReg == RamBlockPkg::cmdRead))
			portRd <= sramDin;
	end

endmodule

//--- design/RamReadWriteArbiter.sv
// Two-channel arbiter in front of the SRAM pin unit.
// Host channel has fixed priority over the tester. One access is in
// flight at a time; the granted requester gets ack after portDone and
// the grant is released once its req drops.
`timescale 1ns/1ps

module RamReadWriteArbiter #(
	parameter pRamAdrsWidth = 18,
	parameter pRamDqWidth = 16
)(
	input  logic sClk,
	input  logic reset,
	// Host channel
	input  logic hostReq,
	input  RamBlockPkg::RamCmd hostCmd,
	input  logic [pRamAdrsWidth-1:0] hostAdrs,
	input  logic [pRamDqWidth-1:0] hostWd,
	output logic hostAck,
	output logic [pRamDqWidth-1:0] hostRd,
	// Tester channel
	input  logic tstReq,
	input  RamBlockPkg::RamCmd tstCmd,
	input  logic [pRamAdrsWidth-1:0] tstAdrs,
	input  logic [pRamDqWidth-1:0] tstWd,
	output logic tstAck,
	output logic [pRamDqWidth-1:0] tstRd,
	// Pin unit
	output logic portStart,
	output RamBlockPkg::RamCmd portCmd,
	output logic [pRamAdrsWidth-1:0] portAdrs,
	output logic [pRamDqWidth-1:0] portWd,
	input  logic [pRamDqWidth-1:0] portRd,
	input  logic portDone
);

	// Bit 0 host, bit 1 tester; zero means idle
	logic [1:0] grant;
	logic [pRamDqWidth-1:0] rdLatch;
	logic ackRelease;

	// Granted requester has closed its side
	assign ackRelease = (hostAck && !hostReq) || (tstAck && !tstReq);

	// Read word is valid on either channel while its ack is high
	assign hostRd = rdLatch;
	assign tstRd  = rdLatch;

	always_ff @(posedge sClk)
	begin
		if (reset)
		begin
			grant <= 2'b00;
			portStart <= 1'b0;
			hostAck <= 1'b0;
			tstAck <= 1'b0;
		end
		else
		begin
			portStart <= 1'b0;
			if (grant == 2'b00)
			begin
				// Fixed priority, host first
				if (hostReq)
				begin
					grant <= 2'b01;
					portStart <= 1'b1;
				end
				else if (tstReq)
				begin
					grant <= 2'b10;
					portStart <= 1'b1;
				end
			end
			else if (portDone)
			begin
				hostAck <= grant[0];
				tstAck <= grant[1];
			end
			else if (ackRelease)
			begin
				hostAck <= 1'b0;
				tstAck <= 1'b0;
				grant <= 2'b00;
			end
		end
	end

	// Command follows the winner while idle and freezes once granted
	always_ff @(posedge sClk)
	begin
		if (grant == 2'b00)
		begin
			portCmd <= hostReq ? hostCmd : tstCmd;
			portAdrs <= hostReq ? hostAdrs : tstAdrs;
			portWd <= hostReq ? hostWd : tstWd;
		end
		if (portDone)
			rdLatch <= portRd;
	end

endmodule

//--- design/MemoryReadWriteTester.sv
// Built-in SRAM tester.
// On testStart it writes seed + 3*address over addresses 0..pTestLength-1,
// then reads the range back and flags any mismatch in the sticky testErr.
// testDone stays high until the next start.
`timescale 1ns/1ps

module MemoryReadWriteTester #(
	parameter pRamAdrsWidth = 18,
	parameter pRamDqWidth = 16,
	parameter pTestLength = 64
)(
	input  logic sClk,
	input  logic reset,
	input  logic testStart,
	input  logic [pRamDqWidth-1:0] testSeed,
	output logic tstReq,
	output RamBlockPkg::RamCmd tstCmd,
	output logic [pRamAdrsWidth-1:0] tstAdrs,
	output logic [pRamDqWidth-1:0] tstWd,
	input  logic tstAck,
	input  logic [pRamDqWidth-1:0] tstRd,
	output logic testDone,
	output logic testErr
);

	RamBlockPkg::TesterState state;
	logic [pRamAdrsWidth-1:0] adrsCnt;
	logic [pRamDqWidth-1:0] seedReg;
	logic [pRamDqWidth-1:0] expWord;
	logic lastAdrs;
	logic reqIdle;
	logic reqDone;
	logic startOk;

	// Pattern word for the current address
	assign expWord  = seedReg + pRamDqWidth'(adrsCnt * 2'd3);
	assign lastAdrs = (adrsCnt == pRamAdrsWidth'(pTestLength - 1));
	// Next req only after the previous ack has dropped
	assign reqIdle  = !tstReq && !tstAck;
	assign reqDone  = tstReq && tstAck;
	// Start is accepted only when no pass is running
	assign startOk  = testStart &&
		((state == RamBlockPkg::tstIdle) || (state == RamBlockPkg::tstDone));

	// Address and data stay put while req is high
	assign tstAdrs  = adrsCnt;
	assign tstWd    = expWord;
	assign tstCmd   = (state == RamBlockPkg::tstRead) ?
		RamBlockPkg::cmdRead : RamBlockPkg::cmdWrite;
	assign testDone = (state == RamBlockPkg::tstDone);

	// Seed is held for the whole run
	always_ff @(posedge sClk)
	begin
		if (startOk)
			seedReg <= testSeed;
	end

	always_ff @(posedge sClk)
	begin
		if (reset)
		begin
			state <= RamBlockPkg::tstIdle;
			adrsCnt <= '0;
			tstReq <= 1'b0;
			testErr <= 1'b0;
		end
		else
		begin
			case (state)
				RamBlockPkg::tstIdle, RamBlockPkg::tstDone:
				begin
					// Fresh run clears the old error
					if (startOk)
					begin
						state <= RamBlockPkg::tstWrite;
						adrsCnt <= '0;
						testErr <= 1'b0;
					end
				end
				RamBlockPkg::tstWrite:
				begin
					if (reqIdle)
						tstReq <= 1'b1;
					else if (reqDone)
					begin
						tstReq <= 1'b0;
						// Last write turns the pass around to read-back
						if (lastAdrs)
						begin
							state <= RamBlockPkg::tstRead;
							adrsCnt <= '0;
						end
						else
							adrsCnt <= adrsCnt + 1'b1;
					end
				end
				RamBlockPkg::tstRead:
				begin
					if (reqIdle)
						tstReq <= 1'b1;
					else if (reqDone)
					begin
						tstReq <= 1'b0;
						// Sticky compare error
						if (tstRd != expWord)
							testErr <= 1'b1;
						if (lastAdrs)
							state <= RamBlockPkg::tstDone;
						else
							adrsCnt <= adrsCnt + 1'b1;
					end
				end
				default:
					state <= RamBlockPkg::tstIdle;
			endcase
		end
	end

endmodule

//--- design/RamCsr.sv
// Host register file of the SRAM block.
// Decodes the block select, keeps address, seed and last read word, and
// turns writes of regWdata or regRdata into one four-phase SRAM request.
// The host polls regStatus bit 0 until the access is complete.
`timescale 1ns/1ps

module RamCsr #(
	parameter pRamAdrsWidth = 18,
	parameter pRamDqWidth = 16,
	parameter pUsiBusWidth = 32,
	parameter [7:0] pAdrsMap = 8'h04
)(
	input  logic sClk,
	input  logic reset,
	input  logic [pUsiBusWidth-1:0] usiAdrs,
	input  logic [pUsiBusWidth-1:0] usiWd,
	input  logic usiWe,
	input  logic usiRe,
	output logic [pUsiBusWidth-1:0] usiRd,
	output logic hostReq,
	output RamBlockPkg::RamCmd hostCmd,
	output logic [pRamAdrsWidth-1:0] hostAdrs,
	output logic [pRamDqWidth-1:0] hostWd,
	input  logic hostAck,
	input  logic [pRamDqWidth-1:0] hostRd,
	output logic testStart,
	output logic [pRamDqWidth-1:0] testSeed,
	input  logic testDone,
	input  logic testErr
);

	RamBlockPkg::CsrReg csrOffset;
	logic blockSel;
	logic csrWrite;
	logic accessGo;
	logic busy;
	logic [pRamAdrsWidth-1:0] ramAdrs;
	logic [pRamDqWidth-1:0] rdata;

	// Block select on bits 15:8, word offset in the low bits
	assign blockSel  = (usiAdrs[15:8] == pAdrsMap);
	assign csrOffset = RamBlockPkg::CsrReg'(usiAdrs[2:0]);
	assign csrWrite  = usiWe && blockSel;
	// New access only when the last one has fully closed
	assign accessGo  = csrWrite && !busy &&
		((csrOffset == RamBlockPkg::regWdata) || (csrOffset == RamBlockPkg::regRdata));

	// Configuration registers
	always_ff @(posedge sClk)
	begin
		if (reset)
		begin
			ramAdrs <= '0;
			testSeed <= '0;
			testStart <= 1'b0;
		end
		else
		begin
			if (csrWrite && (csrOffset == RamBlockPkg::regAdrs))
				ramAdrs <= usiWd[pRamAdrsWidth-1:0];
			if (csrWrite && (csrOffset == RamBlockPkg::regSeed))
				testSeed <= usiWd[pRamDqWidth-1:0];
			// One-cycle start pulse
			testStart <= csrWrite && (csrOffset == RamBlockPkg::regCtrl) && usiWd[0];
		end
	end

	// Request side of the handshake; busy covers all four phases
	always_ff @(posedge sClk)
	begin
		if (reset)
		begin
			hostReq <= 1'b0;
			busy <= 1'b0;
		end
		else if (accessGo)
		begin
			hostReq <= 1'b1;
			busy <= 1'b1;
		end
		else if (hostReq && hostAck)
			hostReq <= 1'b0;
		else if (busy && !hostReq && !hostAck)
			busy <= 1'b0;
	end

	// Request payload and read word capture
	always_ff @(posedge sClk)
	begin
		if (accessGo)
		begin
			hostCmd <= (csrOffset == RamBlockPkg::regWdata) ?
				RamBlockPkg::cmdWrite : RamBlockPkg::cmdRead;
			hostAdrs <= ramAdrs;
			hostWd <= usiWd[pRamDqWidth-1:0];
		end
		if (hostReq && hostAck && (hostCmd == RamBlockPkg::cmdRead))
			rdata <= hostRd;
	end

	// Registered read-back one cycle after usiRe
	always_ff @(posedge sClk)
	begin
		if (reset)
			usiRd <= '0;
		else if (usiRe && blockSel)
		begin
			case (csrOffset)
				RamBlockPkg::regSeed:   usiRd <= pUsiBusWidth'(testSeed);
				RamBlockPkg::regAdrs:   usiRd <= pUsiBusWidth'(ramAdrs);
				RamBlockPkg::regWdata:  usiRd <= pUsiBusWidth'(hostWd);
				RamBlockPkg::regRdata:  usiRd <= pUsiBusWidth'(rdata);
				RamBlockPkg::regStatus: usiRd <= pUsiBusWidth'({testErr, testDone, busy});
				default:                usiRd <= '0;
			endcase
		end
	end

endmodule

//--- design/RamBlock.sv
// External asynchronous SRAM block.
// Host registers and the built-in tester share one SRAM through the arbiter.
// All parameters are set here and handed down to the submodules.
`timescale 1ns/1ps

module RamBlock #(
	parameter pRamAdrsWidth = 18,
	parameter pRamDqWidth = 16,
	parameter pUsiBusWidth = 32,
	parameter [7:0] pAdrsMap = 8'h04,
	parameter pTestLength = 64
)(
	input  logic sClk,
	input  logic reset,
	// Host bus
	input  logic [pUsiBusWidth-1:0] usiAdrs,
	input  logic [pUsiBusWidth-1:0] usiWd,
	input  logic usiWe,
	input  logic usiRe,
	output logic [pUsiBusWidth-1:0] usiRd,
	// SRAM pins, strobes active low
	input  logic [pRamDqWidth-1:0] sramDin,
	output logic [pRamAdrsWidth-1:0] sramA,
	output logic [pRamDqWidth-1:0] sramDout,
	output logic sramDoe,
	output logic sramLb,
	output logic sramUb,
	output logic sramOe,
	output logic sramWe,
	output logic sramCe,
	// Tester status
	output logic testErr,
	output logic testDone
);

//----------------------------------------------------------------------------
// Internal channels
//----------------------------------------------------------------------------
	// Host requester
	logic hostReq, hostAck;
	RamBlockPkg::RamCmd hostCmd;
	logic [pRamAdrsWidth-1:0] hostAdrs;
	logic [pRamDqWidth-1:0] hostWd, hostRd;
	// Tester requester
	logic tstReq, tstAck;
	RamBlockPkg::RamCmd tstCmd;
	logic [pRamAdrsWidth-1:0] tstAdrs;
	logic [pRamDqWidth-1:0] tstWd, tstRd;
	// Arbiter to pin unit
	logic portStart, portDone;
	RamBlockPkg::RamCmd portCmd;
	logic [pRamAdrsWidth-1:0] portAdrs;
	logic [pRamDqWidth-1:0] portWd, portRd;
	// Tester control from the registers
	logic testStart;
	logic [pRamDqWidth-1:0] testSeed;

//----------------------------------------------------------------------------
// Register front end
//----------------------------------------------------------------------------
	RamCsr #(
		.pRamAdrsWidth(pRamAdrsWidth), .pRamDqWidth(pRamDqWidth),
		.pUsiBusWidth(pUsiBusWidth), .pAdrsMap(pAdrsMap)
	) ramCsr0 (
		.sClk(sClk), .reset(reset),
		.usiAdrs(usiAdrs), .usiWd(usiWd), .usiWe(usiWe), .usiRe(usiRe), .usiRd(usiRd),
		.hostReq(hostReq), .hostCmd(hostCmd), .hostAdrs(hostAdrs), .hostWd(hostWd),
		.hostAck(hostAck), .hostRd(hostRd),
		.testStart(testStart), .testSeed(testSeed),
		.testDone(testDone), .testErr(testErr)
	);

//----------------------------------------------------------------------------
// Built-in tester
//----------------------------------------------------------------------------
	MemoryReadWriteTester #(
		.pRamAdrsWidth(pRamAdrsWidth), .pRamDqWidth(pRamDqWidth),
		.pTestLength(pTestLength)
	) tester0 (
		.sClk(sClk), .reset(reset),
		.testStart(testStart), .testSeed(testSeed),
		.tstReq(tstReq), .tstCmd(tstCmd), .tstAdrs(tstAdrs), .tstWd(tstWd),
		.tstAck(tstAck), .tstRd(tstRd),
		.testDone(testDone), .testErr(testErr)
	);

//----------------------------------------------------------------------------
// Arbiter and SRAM pins
//----------------------------------------------------------------------------
	RamReadWriteArbiter #(
		.pRamAdrsWidth(pRamAdrsWidth), .pRamDqWidth(pRamDqWidth)
	) arbiter0 (
		.sClk(sClk), .reset(reset),
		.hostReq(hostReq), .hostCmd(hostCmd), .hostAdrs(hostAdrs), .hostWd(hostWd),
		.hostAck(hostAck), .hostRd(hostRd),
		.tstReq(tstReq), .tstCmd(tstCmd), .tstAdrs(tstAdrs), .tstWd(tstWd),
		.tstAck(tstAck), .tstRd(tstRd),
		.portStart(portStart), .portCmd(portCmd), .portAdrs(portAdrs), .portWd(portWd),
		.portRd(portRd), .portDone(portDone)
	);

	RamIfPortUnit #(
		.pRamAdrsWidth(pRamAdrsWidth), .pRamDqWidth(pRamDqWidth)
	) portUnit0 (
		.sClk(sClk), .reset(reset),
		.portStart(portStart), .portCmd(portCmd), .portAdrs(portAdrs), .portWd(portWd),
		.portRd(portRd), .portDone(portDone),
		.sramDin(sramDin), .sramA(sramA), .sramDout(sramDout), .sramDoe(sramDoe),
		.sramLb(sramLb), .sramUb(sramUb), .sramOe(sramOe), .sramWe(sramWe),
		.sramCe(sramCe)
	);

endmodule

//--- sim/SramModel.sv
// Behavioral asynchronous SRAM for the block testbench.
// Writes while CE, WE and both byte lanes are low; reads while CE and OE are low.
// One data bit can be forced to 1 at a chosen address to model a stuck cell.
`timescale 1ns/1ps

module SramModel #(
	parameter pAdrsWidth = 18,
	parameter pDqWidth = 16,
	parameter pStuckBit = 0
)(
	input  logic [pAdrsWidth-1:0] sramA,
	input  logic [pDqWidth-1:0] sramDout,
	input  logic sramDoe,
	input  logic sramLb,
	input  logic sramUb,
	input  logic sramOe,
	input  logic sramWe,
	input  logic sramCe,
	output logic [pDqWidth-1:0] sramDin,
	// Stuck bit control from the testbench
	input  logic faultEn,
	input  logic [pAdrsWidth-1:0] faultAdrs
);

	localparam logic [pDqWidth-1:0] pStuckMask = {{(pDqWidth-1){1'b0}}, 1'b1} << pStuckBit;

	logic [pDqWidth-1:0] mem [0:(1<<pAdrsWidth)-1];
	logic [pDqWidth-1:0] cellWord;
	logic [pDqWidth-1:0] readWord;

	// Level write during the strobe, data from the pad driver
	always @*
	begin
		if (!sramCe && !sramWe && !sramLb && !sramUb && sramDoe)
			mem[sramA] = sramDout;
	end

	assign cellWord = mem[sramA];
	// Stuck-at-1 cell
	assign readWord = (faultEn && (sramA == faultAdrs)) ? (cellWord | pStuckMask) : cellWord;
	// Undriven bus reads as zero
	assign sramDin  = (!sramCe && !sramOe) ? readWord : '0;

endmodule

//--- sim/RamBlock_checker.sv
// Assertions on the SRAM block handshakes and pin strobes.
// Bound into RamBlock from the testbench.
`timescale 1ns/1ps

module RamBlockChecker (
	input logic sClk,
	input logic reset,
	input logic hostReq,
	input logic hostAck,
	input logic tstReq,
	input logic tstAck,
	input logic portStart,
	input logic portDone,
	input logic sramOe,
	input logic sramWe
);

	// ack only rises inside an open request
	hostAckInReq: assert property (@(posedge sClk) disable iff (reset)
		$rose(hostAck) |-> hostReq)
		else $error("Host ack rose while host req was low");
	tstAckInReq: assert property (@(posedge sClk) disable iff (reset)
		$rose(tstAck) |-> tstReq)
		else $error("Tester ack rose while tester req was low");

	// Request held until acknowledged
	hostReqHeld: assert property (@(posedge sClk) disable iff (reset)
		hostReq && !hostAck |=> hostReq)
		else $error("Host req dropped before its ack");
	tstReqHeld: assert property (@(posedge sClk) disable iff (reset)
		tstReq && !tstAck |=> tstReq)
		else $error("Tester req dropped before its ack");

	// Read and write strobes never overlap
	strobeExclusive: assert property (@(posedge sClk) disable iff (reset)
		!(!sramOe && !sramWe))
		else $error("SRAM OE and WE were low at the same time");

	// Fixed pin unit latency
	portLatency: assert property (@(posedge sClk) disable iff (reset)
		portStart |-> ##3 portDone)
		else $error("portDone did not follow portStart after 3 cycles");

endmodule

//--- sim/RamBlockTb.sv
// Self-checking testbench for the external SRAM block.
// Replays host operations from the test data file over the register bus,
// polls busy and tester done, and compares read words and status flags.
// An SRAM model sits on the pins; the checker is bound into RamBlock.
`timescale 1ns/1ps

module RamBlockTb;

	localparam pRamAdrsWidth = 18;
	localparam pRamDqWidth = 16;
	localparam pUsiBusWidth = 32;
	localparam logic [7:0] pAdrsMap = 8'h04;
	localparam pTestLength = 64;
	localparam pRecordCount = 32;

	// Record operation codes
	localparam logic [3:0] opEnd = 4'h0;
	localparam logic [3:0] opWrite = 4'h1;
	localparam logic [3:0] opRead = 4'h2;
	localparam logic [3:0] opStart = 4'h3;
	localparam logic [3:0] opStartFault = 4'h4;
	localparam logic [3:0] opWait = 4'h5;

	logic sClk;
	logic reset;
	logic [pUsiBusWidth-1:0] usiAdrs;
	logic [pUsiBusWidth-1:0] usiWd;
	logic usiWe;
	logic usiRe;
	logic [pUsiBusWidth-1:0] usiRd;
	logic [pRamDqWidth-1:0] sramDin;
	logic [pRamAdrsWidth-1:0] sramA;
	logic [pRamDqWidth-1:0] sramDout;
	logic sramDoe, sramLb, sramUb, sramOe, sramWe, sramCe;
	logic testErr, testDone;
	logic faultEn;
	logic [pRamAdrsWidth-1:0] faultAdrs;

	// op[75:72] adrs[71:52] data[51:36] fault[35:16] expected[15:0]
	logic [75:0] records [0:pRecordCount-1];
	int errorCount = 0;
	int checkCount = 0;
	int timeoutLimit = 0;
	int cycleCount = 0;

//----------------------------------------------------------------------------
// DUT, SRAM model and checker
//----------------------------------------------------------------------------
	RamBlock #(
		.pRamAdrsWidth(pRamAdrsWidth), .pRamDqWidth(pRamDqWidth),
		.pUsiBusWidth(pUsiBusWidth), .pAdrsMap(pAdrsMap), .pTestLength(pTestLength)
	) dut0 (
		.sClk(sClk), .reset(reset),
		.usiAdrs(usiAdrs), .usiWd(usiWd), .usiWe(usiWe), .usiRe(usiRe), .usiRd(usiRd),
		.sramDin(sramDin), .sramA(sramA), .sramDout(sramDout), .sramDoe(sramDoe),
		.sramLb(sramLb), .sramUb(sramUb), .sramOe(sramOe), .sramWe(sramWe),
		.sramCe(sramCe), .testErr(testErr), .testDone(testDone)
	);

	SramModel #(.pAdrsWidth(pRamAdrsWidth), .pDqWidth(pRamDqWidth), .pStuckBit(0)) sram0 (
		.sramA(sramA), .sramDout(sramDout), .sramDoe(sramDoe), .sramLb(sramLb),
		.sramUb(sramUb), .sramOe(sramOe), .sramWe(sramWe), .sramCe(sramCe),
		.sramDin(sramDin), .faultEn(faultEn), .faultAdrs(faultAdrs)
	);

	bind RamBlock RamBlockChecker checker0 (
		.sClk(sClk), .reset(reset), .hostReq(hostReq), .hostAck(hostAck),
		.tstReq(tstReq), .tstAck(tstAck), .portStart(portStart), .portDone(portDone),
		.sramOe(sramOe), .sramWe(sramWe)
	);

	// 20 ns clock
	initial
	begin
		sClk = 1'b0;
		forever #10 sClk = ~sClk;
	end

	// Run limit is set once the data file is read
	initial
	begin
		while (timeoutLimit == 0 || cycleCount < timeoutLimit)
		begin
			@(posedge sClk);
			cycleCount++;
		end
		$display("Timeout after %0d cycles, the test sequence did not finish", cycleCount);
		$display("Regression failed");
		$finish;
	end

//----------------------------------------------------------------------------
// Bus tasks start and end 2 ns after a rising edge
//----------------------------------------------------------------------------
	task automatic stepCycle();
		@(posedge sClk);
		#2;
	endtask

	task automatic busWrite(input RamBlockPkg::CsrReg offset,
		input logic [pUsiBusWidth-1:0] value);
		usiAdrs = {16'h0000, pAdrsMap, 5'b00000, offset};
		usiWd = value;
		usiWe = 1'b1;
		stepCycle();
		usiWe = 1'b0;
	endtask

	// usiRd is registered and valid right after the sampling edge
	task automatic busRead(input RamBlockPkg::CsrReg offset,
		output logic [pUsiBusWidth-1:0] value);
		usiAdrs = {16'h0000, pAdrsMap, 5'b00000, offset};
		usiRe = 1'b1;
		stepCycle();
		usiRe = 1'b0;
		value = usiRd;
	endtask

	// Poll status bit 0 until the host access has closed
	task automatic waitIdle();
		logic [pUsiBusWidth-1:0] value;
		busRead(RamBlockPkg::regStatus, value);
		while (value[0])
			busRead(RamBlockPkg::regStatus, value);
	endtask

	task automatic hostWrite(input logic [pRamAdrsWidth-1:0] adrs,
		input logic [pRamDqWidth-1:0] word);
		busWrite(RamBlockPkg::regAdrs, pUsiBusWidth'(adrs));
		busWrite(RamBlockPkg::regWdata, pUsiBusWidth'(word));
		waitIdle();
	endtask

	task automatic hostRead(input logic [pRamAdrsWidth-1:0] adrs,
		output logic [pRamDqWidth-1:0] word);
		logic [pUsiBusWidth-1:0] value;
		busWrite(RamBlockPkg::regAdrs, pUsiBusWidth'(adrs));
		busWrite(RamBlockPkg::regRdata, '0);
		waitIdle();
		busRead(RamBlockPkg::regRdata, value);
		word = value[pRamDqWidth-1:0];
	endtask

	// Seed, optional stuck cell, then start; returns once the old done flag is gone
	task automatic startTester(input logic [pRamDqWidth-1:0] seed, input logic withFault,
		input logic [pRamAdrsWidth-1:0] faultAt);
		faultEn = withFault;
		faultAdrs = faultAt;
		busWrite(RamBlockPkg::regSeed, pUsiBusWidth'(seed));
		busWrite(RamBlockPkg::regCtrl, 32'h1);
		while (testDone)
			stepCycle();
	endtask

	task automatic waitTester(output logic [2:0] status);
		logic [pUsiBusWidth-1:0] value;
		while (!testDone)
			stepCycle();
		busRead(RamBlockPkg::regStatus, value);
		status = value[2:0];
	endtask

//----------------------------------------------------------------------------
// Compare tasks
//----------------------------------------------------------------------------
	task automatic checkWord(input string name, input logic [pRamDqWidth-1:0] got,
		input logic [pRamDqWidth-1:0] expected);
		checkCount++;
		if (got !== expected)
		begin
			errorCount++;
			$display("Mismatch %s got 0x%h expected 0x%h", name, got, expected);
		end
	endtask

	task automatic checkStatus(input string name, input logic [2:0] got,
		input logic [2:0] expected);
		checkCount++;
		if (got !== expected)
		begin
			errorCount++;
			$display("Mismatch %s got 0x%h expected 0x%h", name, got, expected);
		end
	endtask

//----------------------------------------------------------------------------
// Main sequence
//----------------------------------------------------------------------------
	initial
	begin
		int gap;
		int budget;
		logic [3:0] op;
		logic [pRamAdrsWidth-1:0] adrs;
		logic [pRamDqWidth-1:0] data;
		logic [pRamAdrsWidth-1:0] faultAt;
		logic [pRamDqWidth-1:0] expected;
		logic [pRamDqWidth-1:0] word;
		logic [2:0] status;
		reset = 1'b1;
		usiAdrs = '0;
		usiWd = '0;
		usiWe = 1'b0;
		usiRe = 1'b0;
		faultEn = 1'b0;
		faultAdrs = '0;
		void'($urandom(29789));
		for (int i = 0; i < pRecordCount; i++)
			records[i] = '0;
		$readmemh("sim/ramblock_testdata.txt", records);
		// 5 cycles per host access, 12 per tester word
		budget = 0;
		for (int i = 0; i < pRecordCount; i++)
		begin
			case (records[i][75:72])
				opWrite, opRead: budget += 5;
				opStart, opStartFault: budget += 12 * pTestLength;
				default: ;
			endcase
		end
		timeoutLimit = 20 * budget;
		repeat (5) @(posedge sClk);
		#2;
		reset = 1'b0;
		for (int i = 0; i < pRecordCount && records[i][75:72] != opEnd; i++)
		begin
			op = records[i][75:72];
			adrs = records[i][69:52];
			data = records[i][51:36];
			faultAt = records[i][33:16];
			expected = records[i][15:0];
			case (op)
				opWrite: hostWrite(adrs, data);
				opRead:
				begin
					hostRead(adrs, word);
					checkWord($sformatf("regRdata[0x%h]", adrs), word, expected);
				end
				opStart: startTester(data, 1'b0, faultAt);
				opStartFault: startTester(data, 1'b1, faultAt);
				opWait:
				begin
					waitTester(status);
					checkStatus("regStatus", status, expected[2:0]);
					// Error pin must agree with the status bit from the record
					checkStatus("testErr", {2'b00, testErr}, {2'b00, expected[2]});
				end
				default:
				begin
					errorCount++;
					$display("Record %0d holds an unknown operation code %h", i, op);
				end
			endcase
			// Random idle gap between host operations
			gap = $urandom_range(3);
			repeat (gap) stepCycle();
		end
		if (checkCount == 0)
		begin
			errorCount++;
			$display("No checks were run, the test data file is missing or empty");
		end
		$display("Checks run: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

//--- verilog.f
design/RamBlockPkg.sv
design/RamIfPortUnit.sv
design/RamReadWriteArbiter.sv
design/MemoryReadWriteTester.sv
design/RamCsr.sv
design/RamBlock.sv
sim/SramModel.sv
sim/RamBlock_checker.sv
sim/RamBlockTb.sv

//--- run.sh
#!/usr/bin/env bash
# Builds the SRAM block regression with Verilator, runs it and checks the log.
set -o pipefail
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module RamBlockTb -f verilog.f \
	&& ./obj_dir/VRamBlockTb 2>&1 | tee sim.log \
	|| { echo "Build or simulation did not complete"; exit 1; }
grep -q "Regression passed" sim.log \
	&& { echo "Result: pass"; exit 0; } \
	|| { echo "Result: fail"; exit 1; }

//--- sim/ramblock_testdata.txt
// Columns: op_adrs_data_fault_expected, hex, one record per line
// op 1 host write, 2 host read, 3 tester start, 4 start with stuck bit, 5 wait and check status
1_00010_BEEF_00000_0000
2_00010_0000_00000_BEEF
1_00100_1111_00000_0000
1_00101_2222_00000_0000
1_3FFFF_A5C3_00000_0000
2_00100_0000_00000_1111
2_00101_0000_00000_2222
2_3FFFF_0000_00000_A5C3
3_00000_1000_00000_0000 // seed 1000
5_00000_0000_00000_0002
2_00000_0000_00000_1000
2_00005_0000_00000_100F
2_0003F_0000_00000_10BD
4_00000_1234_00010_0000 // bit 0 stuck at address 10
5_00000_0000_00000_0006
3_00000_0100_00000_0000 // host traffic while the tester runs
1_00200_C0DE_00000_0000
2_00200_0000_00000_C0DE
5_00000_0000_00000_0002
2_00020_0000_00000_0160
